//--- robocup_motor_ctrl.f
source/robocup_pkg.sv
source/spi_byte_slave.sv
source/quad_encoder_bank.sv
source/motor_watchdog.sv
source/host_command_unit.sv
source/robocup_motor_ctrl.sv
testbench/robocup_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = robocup_tb
FILELIST  = robocup_motor_ctrl.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- testbench/robocup_tb.sv
// Motor control core testbench, an SPI host model running a table of frames against a model
`timescale 1ns/1ps

module robocup_tb;

    localparam int HALF_SCK = 10;
    localparam int CS_GAP = 10;
    localparam int TRIP_LIMIT = 300000;
    localparam int MAX_ROWS = 16;
    localparam int MAX_BYTES = 16;
    // Actions run before a frame
    localparam int PRE_NONE = 0;
    localparam int PRE_ENC = 1;
    localparam int PRE_TRIP = 2;
    // Eighth rising SCK of the command byte, in cycles after chip select falls
    localparam int LAST_RISE = CS_GAP + 15 * HALF_SCK;
    // Sync, byte strobe and command latch put the sample 4 edges later, the clear 2 more
    localparam int SAMPLE_OFS = LAST_RISE + 4;
    localparam int CLEAR_OFS = LAST_RISE + 6;

    logic sysclk;
    logic watchdog_timer_reset_flag;
    logic spi_sck;
    logic spi_mosi;
    logic spi_ncs;
    logic spi_miso;
    logic [robocup_pkg::NUM_MOTORS-1:0] enc_a;
    logic [robocup_pkg::NUM_MOTORS-1:0] enc_b;
    robocup_pkg::duty_array_t duty;
    logic motors_en;

    // Stimulus table
    string row_name [MAX_ROWS];
    robocup_pkg::spi_byte_t row_cmd [MAX_ROWS];
    logic [63:0] row_data [MAX_ROWS];
    int row_len [MAX_ROWS];
    bit row_rnd [MAX_ROWS];
    int row_pre [MAX_ROWS];
    bit row_en [MAX_ROWS];
    bit row_chg [MAX_ROWS];
    int num_rows;

    // Reference model state
    robocup_pkg::duty_array_t model_duty;
    robocup_pkg::enc_array_t model_cnt;
    logic [1:0] enc_state [robocup_pkg::NUM_MOTORS];
    logic model_en;
    logic model_trip;
    // Last edge that held the watchdog at zero
    int wdt_zero;
    int cycle;
    int frame_c0;
    logic [15:0] lfsr;
    robocup_pkg::spi_byte_t tx_buf [MAX_BYTES];
    robocup_pkg::spi_byte_t rx_buf [MAX_BYTES];
    robocup_pkg::spi_byte_t exp_buf [MAX_BYTES];
    int errors;
    int checks;

    robocup_motor_ctrl dut (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .spi_sck_i                 (spi_sck),
        .spi_mosi_i                (spi_mosi),
        .spi_ncs_i                 (spi_ncs),
        .spi_miso_o                (spi_miso),
        .enc_a_i                   (enc_a),
        .enc_b_i                   (enc_b),
        .duty_o                    (duty),
        .motors_en_o               (motors_en)
    );

    always #2 sysclk = ~sysclk;

    // Posedge count, read on negedges for frame timing
    always @(posedge sysclk) begin
        cycle <= cycle + 1;
    end

    task automatic check_byte(input string name, input robocup_pkg::spi_byte_t exp,
                              input robocup_pkg::spi_byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_duty(input string name, input robocup_pkg::duty_array_t exp,
                              input robocup_pkg::duty_array_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input robocup_pkg::wdt_count_t exp,
                               input robocup_pkg::wdt_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail time=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    task automatic add_row(input string name, input robocup_pkg::spi_byte_t cmd,
                           input logic [63:0] data, input int len, input bit rnd,
                           input int pre, input bit en, input bit chg);
        row_name[num_rows] = name;
        row_cmd[num_rows] = cmd;
        row_data[num_rows] = data;
        row_len[num_rows] = len;
        row_rnd[num_rows] = rnd;
        row_pre[num_rows] = pre;
        row_en[num_rows] = en;
        row_chg[num_rows] = chg;
        num_rows++;
    endtask

    // Commands: 80 update read, 91 encoder read, 93 duty read, 30/B0 toggle write/read
    task automatic build_table();
        add_row("reset duty read", 8'h93, 64'h0, 9, 0, PRE_NONE, 0, 0);
        add_row("motor update", 8'h80, 64'h0, 9, 1, PRE_NONE, 1, 1);
        add_row("duty echo", 8'h93, 64'h0, 9, 0, PRE_NONE, 1, 0);
        add_row("update one byte short", 8'h80, 64'h0, 8, 1, PRE_NONE, 1, 0);
        add_row("update one byte long", 8'h80, 64'h0, 10, 1, PRE_NONE, 1, 0);
        add_row("encoder count read", 8'h91, 64'h0, 11, 0, PRE_ENC, 1, 0);
        add_row("update returns counts", 8'h80, 64'h0, 9, 1, PRE_NONE, 1, 1);
        add_row("encoder counts cleared", 8'h91, 64'h0, 11, 0, PRE_NONE, 1, 0);
        add_row("toggle write disables", 8'h30, 64'hA500_0000_0000_0000, 2, 0, PRE_NONE, 0, 0);
        add_row("toggle read enables", 8'hB0, 64'hA500_0000_0000_0000, 2, 0, PRE_NONE, 1, 0);
        add_row("unknown read opcode", 8'hC5, 64'h0123_4567_89AB_CDEF, 12, 0, PRE_NONE, 1, 0);
        add_row("status after trip", 8'h93, 64'h0, 9, 0, PRE_TRIP, 0, 0);
        add_row("update after trip", 8'h80, 64'h0, 9, 1, PRE_NONE, 1, 1);
        add_row("status after recovery", 8'h93, 64'h0, 9, 0, PRE_NONE, 1, 0);
    endtask

    // One frame, mode 0, MSB first; MISO is sampled just before each rising SCK
    task automatic spi_frame(input int len);
        robocup_pkg::spi_byte_t shreg;
        robocup_pkg::spi_byte_t got;
        spi_ncs = 1'b0;
        frame_c0 = cycle;
        wait_cycles(CS_GAP);
        for (int b = 0; b < len; b++) begin
            shreg = tx_buf[b];
            got = '0;
            for (int k = 0; k < robocup_pkg::SPI_BYTE_WIDTH; k++) begin
                spi_mosi = shreg[robocup_pkg::SPI_BYTE_WIDTH-1-k];
                wait_cycles(HALF_SCK);
                got = {got[robocup_pkg::SPI_BYTE_WIDTH-2:0], spi_miso};
                spi_sck = 1'b1;
                wait_cycles(HALF_SCK);
                spi_sck = 1'b0;
            end
            rx_buf[b] = got;
        end
        wait_cycles(CS_GAP);
        spi_ncs = 1'b1;
        spi_mosi = 1'b0;
        // Writes land 4 cycles after chip select rises
        wait_cycles(CS_GAP);
    endtask

    // One quadrature state per call, order 00 10 11 01 as (A, B) going forward
    task automatic enc_step(input int m, input logic fwd);
        if (fwd) begin
            enc_state[m] = enc_state[m] + 2'd1;
            model_cnt[m] = model_cnt[m] + 16'd1;
        end else begin
            enc_state[m] = enc_state[m] - 2'd1;
            model_cnt[m] = model_cnt[m] - 16'd1;
        end
        enc_a[m] = enc_state[m][0] ^ enc_state[m][1];
        enc_b[m] = enc_state[m][1];
        wait_cycles(4);
    endtask

    task automatic walk_encoders();
        logic [15:0] r;
        int steps;
        for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
            take_bits(4, r);
            steps = r + 1;
            for (int s = 0; s < steps; s++) begin
                take_bits(1, r);
                enc_step(m, r[0]);
            end
        end
        wait_cycles(8);
    endtask

    task automatic wait_for_trip();
        int n;
        n = 0;
        while (motors_en !== 1'b0 && n < TRIP_LIMIT) begin
            @(negedge sysclk);
            n++;
        end
        if (motors_en !== 1'b0) begin
            errors++;
            $display("Timeout: watchdog never dropped motors_en_o within %0d cycles", n);
        end
        model_trip = 1'b1;
        model_en = 1'b0;
    endtask

    // Response bytes from the layout rules and the model
    task automatic build_expected(input robocup_pkg::spi_byte_t cmd,
                                  output robocup_pkg::wdt_count_t wdt);
        logic [6:0] op;
        int ticks;
        op = cmd[6:0];
        // One tick per 4 cycles since the last zeroing edge, wraps with the counter
        ticks = (frame_c0 + SAMPLE_OFS - wdt_zero) / 4;
        wdt = ticks[15:0];
        exp_buf[0] = '0;
        exp_buf[0][robocup_pkg::STATUS_TRIP_BIT] = model_trip;
        exp_buf[0][robocup_pkg::STATUS_EN_BIT] = model_en;
        for (int i = 1; i < MAX_BYTES; i++) begin
            exp_buf[i] = robocup_pkg::FILL_BYTE;
        end
        if (cmd[7] && (op == robocup_pkg::OP_UPDATE_MTRS || op == robocup_pkg::OP_ENCODER_COUNT)) begin
            for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                exp_buf[2*m+1] = model_cnt[m][15:8];
                exp_buf[2*m+2] = model_cnt[m][7:0];
            end
            exp_buf[9] = wdt[15:8];
            exp_buf[10] = wdt[7:0];
        end else if (cmd[7] && op == robocup_pkg::OP_DUTY_CYCLE) begin
            for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                exp_buf[2*m+1] = {6'b0, model_duty[m][9:8]};
                exp_buf[2*m+2] = model_duty[m][7:0];
            end
        end
    endtask

    initial begin
        robocup_pkg::spi_byte_t cmd;
        robocup_pkg::duty_array_t new_duty;
        robocup_pkg::wdt_count_t exp_wdt;
        logic [15:0] r;
        bit cnt_read;
        bit upd_read;
        int err_before;
        sysclk = 1'b0;
        watchdog_timer_reset_flag = 1'b1;
        spi_sck = 1'b0;
        spi_mosi = 1'b0;
        spi_ncs = 1'b1;
        enc_a = '0;
        enc_b = '0;
        cycle = 0;
        lfsr = 16'd14;
        errors = 0;
        checks = 0;
        num_rows = 0;
        model_duty = '0;
        model_cnt = '0;
        model_en = 1'b0;
        model_trip = 1'b0;
        new_duty = '0;
        for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
            enc_state[m] = 2'd0;
        end
        build_table();
        wait_cycles(4);
        watchdog_timer_reset_flag = 1'b0;
        wdt_zero = cycle;
        wait_cycles(2);
        check_bit("motors_en_o", 1'b0, motors_en);
        check_duty("duty_o", '0, duty);
        check_bit("spi_miso_o", 1'b0, spi_miso);
        $display("Reset state: %0d errors", errors);

        for (int t = 0; t < num_rows; t++) begin
            err_before = errors;
            cmd = row_cmd[t];
            if (row_pre[t] == PRE_ENC) begin
                walk_encoders();
            end else if (row_pre[t] == PRE_TRIP) begin
                wait_for_trip();
            end
            for (int i = 0; i < MAX_BYTES; i++) begin
                tx_buf[i] = '0;
            end
            tx_buf[0] = cmd;
            if (row_rnd[t]) begin
                // Duties go out low byte first
                for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                    take_bits(robocup_pkg::DUTY_WIDTH, r);
                    new_duty[m] = r[9:0];
                    tx_buf[2*m+1] = r[7:0];
                    tx_buf[2*m+2] = {6'b0, r[9:8]};
                end
                take_bits(8, r);
                tx_buf[9] = r[7:0];
            end else begin
                for (int i = 1; i <= 8; i++) begin
                    tx_buf[i] = row_data[t][8*(8-i) +: 8];
                end
            end
            spi_frame(row_len[t]);

            build_expected(cmd, exp_wdt);
            upd_read = cmd[7] && cmd[6:0] == robocup_pkg::OP_UPDATE_MTRS;
            cnt_read = upd_read || (cmd[7] && cmd[6:0] == robocup_pkg::OP_ENCODER_COUNT);
            for (int i = 0; i < row_len[t]; i++) begin
                if (!(cnt_read && row_len[t] > 10 && (i == 9 || i == 10))) begin
                    check_byte($sformatf("spi_miso_o byte %0d", i), exp_buf[i], rx_buf[i]);
                end
            end
            if (cnt_read && row_len[t] > 10) begin
                check_count("spi_miso_o watchdog count", exp_wdt, {rx_buf[9], rx_buf[10]});
            end

            // Any update read clears the counters and rearms the watchdog
            if (upd_read) begin
                model_cnt = '0;
                model_trip = 1'b0;
                wdt_zero = frame_c0 + CLEAR_OFS;
            end
            if (row_chg[t]) begin
                model_duty = new_duty;
            end
            model_en = row_en[t];
            check_bit("motors_en_o", model_en, motors_en);
            check_duty("duty_o", model_duty, duty);
            $display("Row %0d %s: %0d errors", t, row_name[t], errors - err_before);
        end

        $display("Summary: %0d tests, %0d checks, %0d errors", num_rows + 1, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/robocup_motor_ctrl.sv
// Motor board control core top level joining SPI, encoders, watchdog and command unit
`timescale 1ns/1ps

module robocup_motor_ctrl (
    input  logic                               sysclk,
    input  logic                               watchdog_timer_reset_flag,
    input  logic                               spi_sck_i,
    input  logic                               spi_mosi_i,
    input  logic                               spi_ncs_i,
    output logic                               spi_miso_o,
    input  logic [robocup_pkg::NUM_MOTORS-1:0] enc_a_i,
    input  logic [robocup_pkg::NUM_MOTORS-1:0] enc_b_i,
    output robocup_pkg::duty_array_t           duty_o,
    output logic                               motors_en_o
);

    robocup_pkg::spi_byte_t  rx_byte;
    robocup_pkg::spi_byte_t  tx_byte;
    logic                    byte_done;
    logic                    frame_start;
    logic                    frame_end;
    logic                    counts_clear;
    robocup_pkg::enc_array_t enc_counts;
    robocup_pkg::wdt_count_t wdt_count;
    logic                    wdt_tripped;

    // SPI front end
    spi_byte_slave u_spi (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .spi_sck_i                 (spi_sck_i),
        .spi_mosi_i                (spi_mosi_i),
        .spi_ncs_i                 (spi_ncs_i),
        .spi_miso_o                (spi_miso_o),
        .tx_byte_i                 (tx_byte),
        .rx_byte_o                 (rx_byte),
        .byte_done_o               (byte_done),
        .frame_start_o             (frame_start),
        .frame_end_o               (frame_end)
    );

    // Encoder bank and watchdog run side by side, both cleared by update reads
    quad_encoder_bank u_enc (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .enc_a_i                   (enc_a_i),
        .enc_b_i                   (enc_b_i),
        .counts_clear_i            (counts_clear),
        .enc_counts_o              (enc_counts)
    );

    motor_watchdog u_wdt (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .counts_clear_i            (counts_clear),
        .wdt_count_o               (wdt_count),
        .wdt_tripped_o             (wdt_tripped)
    );

    host_command_unit u_cmd (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .rx_byte_i                 (rx_byte),
        .byte_done_i               (byte_done),
        .frame_start_i             (frame_start),
        .frame_end_i               (frame_end),
        .tx_byte_o                 (tx_byte),
        .enc_counts_i              (enc_counts),
        .wdt_count_i               (wdt_count),
        .wdt_tripped_i             (wdt_tripped),
        .counts_clear_o            (counts_clear),
        .duty_o                    (duty_o),
        .motors_en_o               (motors_en_o)
    );

endmodule

//--- source/host_command_unit.sv
// Host command unit that buffers SPI frames, builds responses and holds duties and enable
`timescale 1ns/1ps

module host_command_unit (
    input  logic                     sysclk,
    input  logic                     watchdog_timer_reset_flag,
    input  robocup_pkg::spi_byte_t   rx_byte_i,
    input  logic                     byte_done_i,
    input  logic                     frame_start_i,
    input  logic                     frame_end_i,
    output robocup_pkg::spi_byte_t   tx_byte_o,
    input  robocup_pkg::enc_array_t  enc_counts_i,
    input  robocup_pkg::wdt_count_t  wdt_count_i,
    input  logic                     wdt_tripped_i,
    output logic                     counts_clear_o,
    output robocup_pkg::duty_array_t duty_o,
    output logic                     motors_en_o
);

    robocup_pkg::spi_byte_t req_buf [robocup_pkg::RES_BUF_LEN];
    robocup_pkg::spi_byte_t res_buf [robocup_pkg::RES_BUF_LEN];
    logic [robocup_pkg::BYTE_COUNT_WIDTH-1:0] byte_count;
    logic byte_done_d;
    logic cmd_load;
    robocup_pkg::opcode_e cmd_now_op;
    logic cmd_now_rd;
    robocup_pkg::opcode_e cmd_op;
    logic cmd_rd;
    robocup_pkg::spi_byte_t status_byte;
    robocup_pkg::duty_array_t duty_q;
    logic motors_en_q;

    // Command byte sits in req_buf[0] one cycle after the first byte_done
    assign cmd_load = byte_done_d && (byte_count == 1);
    assign cmd_now_op = robocup_pkg::opcode_e'(req_buf[0][robocup_pkg::SPI_BYTE_WIDTH-2:0]);
    assign cmd_now_rd = req_buf[0][robocup_pkg::SPI_BYTE_WIDTH-1];

    always_comb begin
        status_byte = '0;
        status_byte[robocup_pkg::STATUS_TRIP_BIT] = wdt_tripped_i;
        status_byte[robocup_pkg::STATUS_EN_BIT] = motors_en_q;
    end

    // Byte counter saturates so long frames never wrap back into the buffer
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            byte_count <= '0;
            byte_done_d <= 1'b0;
        end else begin
            byte_done_d <= byte_done_i;
            if (frame_start_i) begin
                byte_count <= '0;
            end else if (byte_done_i && byte_count != '1) begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    // Request buffer
    always_ff @(posedge sysclk) begin
        if (byte_done_i && byte_count < robocup_pkg::RES_BUF_LEN) begin
            req_buf[byte_count] <= rx_byte_i;
        end
    end

    // Response buffer
    // Byte 0 is the status at frame start, the rest follow the command byte
    always_ff @(posedge sysclk) begin
        if (frame_start_i) begin
            res_buf[0] <= status_byte;
        end
        if (cmd_load) begin
            // Anything the command does not fill reads as fill bytes
            for (int i = 1; i < robocup_pkg::RES_BUF_LEN; i++) begin
                res_buf[i] <= robocup_pkg::FILL_BYTE;
            end
            if (cmd_now_rd) begin
                case (cmd_now_op)
                    robocup_pkg::OP_UPDATE_MTRS, robocup_pkg::OP_ENCODER_COUNT: begin
                        // Counts high byte first, then the watchdog count before any clear
                        for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                            res_buf[2*m+1] <= enc_counts_i[m][15:8];
                            res_buf[2*m+2] <= enc_counts_i[m][7:0];
                        end
                        res_buf[2*robocup_pkg::NUM_MOTORS+1] <= wdt_count_i[15:8];
                        res_buf[2*robocup_pkg::NUM_MOTORS+2] <= wdt_count_i[7:0];
                    end
                    robocup_pkg::OP_DUTY_CYCLE: begin
                        // Top two duty bits padded into the high byte
                        for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                            res_buf[2*m+1] <= {6'b0, duty_q[m][9:8]};
                            res_buf[2*m+2] <= duty_q[m][7:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Beyond the buffer the host shifts out fill
    assign tx_byte_o = (byte_count < robocup_pkg::RES_BUF_LEN) ? res_buf[byte_count]
                                                                : robocup_pkg::FILL_BYTE;

    // Command latch, watchdog clear and frame-end writes
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            cmd_op <= robocup_pkg::OP_UPDATE_MTRS;
            cmd_rd <= 1'b0;
            counts_clear_o <= 1'b0;
            duty_q <= '0;
            motors_en_q <= 1'b0;
        end else begin
            counts_clear_o <= cmd_load && cmd_now_rd && (cmd_now_op == robocup_pkg::OP_UPDATE_MTRS);
            if (cmd_load) begin
                cmd_op <= cmd_now_op;
                cmd_rd <= cmd_now_rd;
            end
            if (frame_end_i) begin
                if (cmd_rd && cmd_op == robocup_pkg::OP_UPDATE_MTRS &&
                    byte_count == 1 + 2 * robocup_pkg::NUM_MOTORS) begin
                    // Duties arrive low byte first
                    for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                        duty_q[m] <= {req_buf[2*m+2][1:0], req_buf[2*m+1]};
                    end
                    motors_en_q <= 1'b1;
                end else if (cmd_op == robocup_pkg::OP_TOGGLE_MOTOR_EN && byte_count == 2) begin
                    // Read type enables, write type disables
                    motors_en_q <= cmd_rd;
                end
            end
            // Trip wins over any frame write
            if (wdt_tripped_i) begin
                motors_en_q <= 1'b0;
            end
        end
    end

    assign duty_o = duty_q;
    assign motors_en_o = motors_en_q;

    a_clear_pulse: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        counts_clear_o |=> !counts_clear_o)
        else $error("counts_clear_o held longer than one cycle");

endmodule

//--- source/motor_watchdog.sv
// Motor watchdog that trips when the host stops sending motor updates
`timescale 1ns/1ps

module motor_watchdog (
    input  logic                    sysclk,
    input  logic                    watchdog_timer_reset_flag,
    input  logic                    counts_clear_i,
    output robocup_pkg::wdt_count_t wdt_count_o,
    output logic                    wdt_tripped_o
);

    logic [robocup_pkg::WDT_PRESCALE_WIDTH-1:0] prescale;
    robocup_pkg::wdt_count_t count_q;
    logic tripped_q;
    logic tick;

    // One tick per full prescaler turn
    assign tick = &prescale;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag || counts_clear_i) begin
            // Host update restarts the timeout and rearms the trip
            prescale <= '0;
            count_q <= '0;
            tripped_q <= 1'b0;
        end else begin
            prescale <= prescale + 1'b1;
            if (tick) begin
                if (count_q == '1) begin
                    // Overflow, the trip stays set until the next clear
                    tripped_q <= 1'b1;
                    count_q <= '0;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    assign wdt_count_o = count_q;
    assign wdt_tripped_o = tripped_q;

    // Clear from the command unit restarts the count on the next edge
    a_clear_zeroes: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        counts_clear_i |=> (wdt_count_o == '0))
        else $error("Watchdog count not zero after a clear");

endmodule

//--- source/quad_encoder_bank.sv
// Quadrature decoder bank with one 16-bit up/down counter per drive encoder
`timescale 1ns/1ps

module quad_encoder_bank (
    input  logic                                sysclk,
    input  logic                                watchdog_timer_reset_flag,
    input  logic [robocup_pkg::NUM_MOTORS-1:0]  enc_a_i,
    input  logic [robocup_pkg::NUM_MOTORS-1:0]  enc_b_i,
    input  logic                                counts_clear_i,
    output robocup_pkg::enc_array_t             enc_counts_o
);

    // Two sync stages plus a previous-value stage per channel
    logic [robocup_pkg::NUM_MOTORS-1:0] a_s1, a_s2, a_s3;
    logic [robocup_pkg::NUM_MOTORS-1:0] b_s1, b_s2, b_s3;
    logic [robocup_pkg::NUM_MOTORS-1:0] a_chg;
    logic [robocup_pkg::NUM_MOTORS-1:0] b_chg;
    logic [robocup_pkg::NUM_MOTORS-1:0] step;
    logic [robocup_pkg::NUM_MOTORS-1:0] count_up;
    robocup_pkg::enc_array_t counts_q;

    // Synchronizers track the pins through reset so no step appears when it ends
    always_ff @(posedge sysclk) begin
        a_s1 <= enc_a_i;
        a_s2 <= a_s1;
        a_s3 <= a_s2;
        b_s1 <= enc_b_i;
        b_s2 <= b_s1;
        b_s3 <= b_s2;
    end

    assign a_chg = a_s2 ^ a_s3;
    assign b_chg = b_s2 ^ b_s3;
    // A legal step moves exactly one channel
    assign step = a_chg ^ b_chg;
    // New A against old B gives the direction, A leading counts up
    assign count_up = a_s2 ^ b_s3;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag || counts_clear_i) begin
            // A step landing on the clear is dropped
            counts_q <= '0;
        end else begin
            for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
                if (step[m]) begin
                    if (count_up[m]) begin
                        counts_q[m] <= counts_q[m] + 1'b1;
                    end else begin
                        counts_q[m] <= counts_q[m] - 1'b1;
                    end
                end
            end
        end
    end

    assign enc_counts_o = counts_q;

    // Both channels moving at once means a skipped quadrature state
    a_no_jump: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        (a_chg & b_chg) == '0)
        else $error("Encoder jumped two quadrature states at once");

endmodule

//--- source/spi_byte_slave.sv
// SPI mode 0 byte slave that synchronizes the pins and frames bytes for the command unit
`timescale 1ns/1ps

module spi_byte_slave (
    input  logic                  sysclk,
    input  logic                  watchdog_timer_reset_flag,
    input  logic                  spi_sck_i,
    input  logic                  spi_mosi_i,
    input  logic                  spi_ncs_i,
    output logic                  spi_miso_o,
    input  robocup_pkg::spi_byte_t tx_byte_i,
    output robocup_pkg::spi_byte_t rx_byte_o,
    output logic                  byte_done_o,
    output logic                  frame_start_o,
    output logic                  frame_end_o
);

    // Stage 0 and 1 synchronize, stage 2 holds the previous value for edge detect
    logic [2:0] sck_sr;
    logic [2:0] ncs_sr;
    logic [1:0] mosi_sr;
    logic [$clog2(robocup_pkg::SPI_BYTE_WIDTH)-1:0] bit_cnt;
    robocup_pkg::spi_byte_t rx_shift;
    robocup_pkg::spi_byte_t tx_shift;
    // Delays the transmit reload until the command unit has its byte ready
    logic [1:0] load_sr;
    logic sck_rise;
    logic sck_fall;

    // SCK edges only count inside a frame
    assign sck_rise = sck_sr[1] & ~sck_sr[2] & ~ncs_sr[1];
    assign sck_fall = ~sck_sr[1] & sck_sr[2] & ~ncs_sr[1];

    // MISO held low while deselected
    assign spi_miso_o = ~ncs_sr[1] & tx_shift[robocup_pkg::SPI_BYTE_WIDTH-1];

    // Chip select idles high out of reset
    always_ff @(posedge sysclk) begin
        sck_sr <= {sck_sr[1:0], spi_sck_i};
        mosi_sr <= {mosi_sr[0], spi_mosi_i};
        if (watchdog_timer_reset_flag) begin
            ncs_sr <= '1;
        end else begin
            ncs_sr <= {ncs_sr[1:0], spi_ncs_i};
        end
    end

    // Framing strobes and bit counter
    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            bit_cnt <= '0;
            byte_done_o <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o <= 1'b0;
            load_sr <= '0;
        end else begin
            frame_start_o <= ~ncs_sr[1] & ncs_sr[2];
            frame_end_o <= ncs_sr[1] & ~ncs_sr[2];
            byte_done_o <= sck_rise && (bit_cnt == robocup_pkg::SPI_BYTE_WIDTH - 1);
            load_sr <= {load_sr[0], frame_start_o | byte_done_o};
            if (ncs_sr[1]) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                // Wraps to zero on the eighth bit
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Receive shifter, MSB first on rising SCK
    always_ff @(posedge sysclk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[robocup_pkg::SPI_BYTE_WIDTH-2:0], mosi_sr[1]};
            if (bit_cnt == robocup_pkg::SPI_BYTE_WIDTH - 1) begin
                rx_byte_o <= {rx_shift[robocup_pkg::SPI_BYTE_WIDTH-2:0], mosi_sr[1]};
            end
        end
    end

    // Transmit shifter
    // No shift on the falling edge after a full byte, the next MSB is already out
    always_ff @(posedge sysclk) begin
        if (load_sr[1]) begin
            tx_shift <= tx_byte_i;
        end else if (sck_fall && bit_cnt != '0) begin
            tx_shift <= {tx_shift[robocup_pkg::SPI_BYTE_WIDTH-2:0], 1'b0};
        end
    end

    // Byte completion must fall inside the chip select window
    a_byte_in_frame: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        byte_done_o |-> !ncs_sr[1])
        else $error("byte_done_o pulsed with chip select high");

endmodule

//--- source/robocup_pkg.sv
// Shared sizes, types and SPI command encodings for the motor control core
package robocup_pkg;

    // Drive motors, one encoder each
    localparam int unsigned NUM_MOTORS = 4;
    localparam int unsigned DUTY_WIDTH = 10;
    localparam int unsigned ENC_COUNT_WIDTH = 16;

    // Watchdog advances once every 2^WDT_PRESCALE_WIDTH cycles
    localparam int unsigned WDT_PRESCALE_WIDTH = 2;
    localparam int unsigned WDT_COUNT_WIDTH = 16;

    // SPI framing
    localparam int unsigned SPI_BYTE_WIDTH = 8;
    localparam int unsigned RES_BUF_LEN = 12;
    localparam int unsigned BYTE_COUNT_WIDTH = 4;

    // Status byte layout, unnamed bits read as zero
    localparam int unsigned STATUS_TRIP_BIT = 7;
    localparam int unsigned STATUS_EN_BIT = 6;

    typedef logic [SPI_BYTE_WIDTH-1:0] spi_byte_t;
    typedef logic [WDT_COUNT_WIDTH-1:0] wdt_count_t;
    typedef logic [NUM_MOTORS-1:0][DUTY_WIDTH-1:0] duty_array_t;
    typedef logic [NUM_MOTORS-1:0][ENC_COUNT_WIDTH-1:0] enc_array_t;

    // Returned for any read opcode that is not decoded
    localparam spi_byte_t FILL_BYTE = 8'hAA;

    // Host opcodes, bits 6:0 of the command byte
    // Bit 7 of the command byte is the read flag
    typedef enum logic [6:0] {
        OP_UPDATE_MTRS     = 7'h00,
        OP_ENCODER_COUNT   = 7'h11,
        OP_DUTY_CYCLE      = 7'h13,
        OP_TOGGLE_MOTOR_EN = 7'h30
    } opcode_e;

endpackage
